// ==== source/cpuPkg.sv ====
package cpuPkg;

	////////////////////////////////////////////////////////////
	// Widths
	typedef logic [31:0] word;      // Data or address
	typedef logic [4:0]  regAddr;   // GPR number
	typedef logic [4:0]  shiftAmt;  // sll shift field
	typedef logic [5:0]  opField;   // Opcode or function code

	localparam word    resetPc          = 32'h0000_3000; // First fetch address
	localparam int     dataMemWords     = 1024;
	localparam int     dataMemIndexBits = $clog2(dataMemWords);
	localparam regAddr linkReg          = 5'd31;         // jal writes here

	////////////////////////////////////////////////////////////
	// Opcodes and function codes
	localparam opField opSpecial = 6'h00;
	localparam opField opJ       = 6'h02;
	localparam opField opJal     = 6'h03;
	localparam opField opBeq     = 6'h04;
	localparam opField opOri     = 6'h0d;
	localparam opField opLui     = 6'h0f;
	localparam opField opLw      = 6'h23;
	localparam opField opSw      = 6'h2b;

	localparam opField fnSll  = 6'h00;
	localparam opField fnJr   = 6'h08;
	localparam opField fnAddu = 6'h21;
	localparam opField fnSubu = 6'h23;

	typedef enum logic [3:0] {
		clsNop, clsAddu, clsSubu, clsOri, clsLui, clsSll,
		clsLw, clsSw, clsBeq, clsJ, clsJal, clsJr
	} instrClass;

	// Where a decode operand comes from
	typedef enum logic [1:0] {
		fromRegFile,
		fromDecodeEx,  // Early result in ID/EX
		fromExMem,     // ALU result
		fromMemWb      // Write-back value
	} operandSource;

	////////////////////////////////////////////////////////////
	// Pipeline registers
	typedef struct packed {
		instrClass opClass;
		regAddr    destination;  // 0 when nothing is written
		word       rsValue;
		word       rtValue;
		word       imm;
		shiftAmt   shamt;
		word       earlyResult;  // lui and jal value
		logic      resultReady;
		word       pc;
	} idExReg;

	typedef struct packed {
		instrClass opClass;
		regAddr    destination;
		word       aluResult;
		word       storeData;
		logic      resultReady;
		word       pc;
	} exMemReg;

	typedef struct packed {
		logic   writeEnable;
		regAddr destination;
		word    data;
		word    pc;
	} memWbReg;

	// Bubble contents
	localparam idExReg idExNop = '{opClass: clsNop, destination: '0, rsValue: '0,
		rtValue: '0, imm: '0, shamt: '0, earlyResult: '0, resultReady: 1'b1, pc: resetPc};
	localparam exMemReg exMemNop = '{opClass: clsNop, destination: '0, aluResult: '0,
		storeData: '0, resultReady: 1'b1, pc: resetPc};
	localparam memWbReg memWbNop = '{writeEnable: 1'b0, destination: '0, data: '0,
		pc: resetPc};

endpackage

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage (
	input  logic        clk,
	input  logic        reset,
	input  logic        stall,
	input  logic        redirect,
	input  cpuPkg::word redirectPc,
	input  cpuPkg::word instrData,
	output cpuPkg::word instrAddr,
	output cpuPkg::word ifIdInstr,
	output cpuPkg::word ifIdPc
);
	cpuPkg::word pc;

	assign instrAddr = pc; // Memory answers in the same cycle

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc        <= cpuPkg::resetPc;
			ifIdInstr <= '0;               // sll $0,$0,0
			ifIdPc    <= cpuPkg::resetPc;
		end
		else if (!stall)
		begin
			// Branch in decode means the word fetched now is its delay slot
			pc        <= redirect ? redirectPc : pc + 32'd4;
			ifIdInstr <= instrData;
			ifIdPc    <= pc;
		end
	end

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
	input  cpuPkg::word       instr,
	output cpuPkg::instrClass opClass,
	output cpuPkg::regAddr    rs,
	output cpuPkg::regAddr    rt,
	output cpuPkg::regAddr    destination,
	output logic              zeroExtend,
	output logic              readyAtId,
	output logic              readyAtEx
);
	cpuPkg::opField opcode;
	cpuPkg::opField funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	// Class lookup
	always_comb
	begin
		opClass = cpuPkg::clsNop; // Unknown words behave as nop
		if (instr != '0)
		begin
			case (opcode)
				cpuPkg::opSpecial:
				begin
					case (funct)
						cpuPkg::fnAddu: opClass = cpuPkg::clsAddu;
						cpuPkg::fnSubu: opClass = cpuPkg::clsSubu;
						cpuPkg::fnSll:  opClass = cpuPkg::clsSll;
						cpuPkg::fnJr:   opClass = cpuPkg::clsJr;
						default:        opClass = cpuPkg::clsNop;
					endcase
				end
				cpuPkg::opOri: opClass = cpuPkg::clsOri;
				cpuPkg::opLui: opClass = cpuPkg::clsLui;
				cpuPkg::opLw:  opClass = cpuPkg::clsLw;
				cpuPkg::opSw:  opClass = cpuPkg::clsSw;
				cpuPkg::opBeq: opClass = cpuPkg::clsBeq;
				cpuPkg::opJ:   opClass = cpuPkg::clsJ;
				cpuPkg::opJal: opClass = cpuPkg::clsJal;
				default:       opClass = cpuPkg::clsNop;
			endcase
		end
	end

	// Unused sources stay at 0 so they never hit a hazard
	always_comb
	begin
		rs          = '0;
		rt          = '0;
		destination = '0;
		case (opClass)
			cpuPkg::clsAddu, cpuPkg::clsSubu:
			begin
				rs          = instr[25:21];
				rt          = instr[20:16];
				destination = instr[15:11];
			end
			cpuPkg::clsSll:
			begin
				rt          = instr[20:16];
				destination = instr[15:11]; // Shift amount replaces rs
			end
			cpuPkg::clsOri, cpuPkg::clsLw:
			begin
				rs          = instr[25:21];
				destination = instr[20:16];
			end
			cpuPkg::clsLui: destination = instr[20:16];
			cpuPkg::clsSw, cpuPkg::clsBeq:
			begin
				rs = instr[25:21];
				rt = instr[20:16];
			end
			cpuPkg::clsJr:  rs = instr[25:21];
			cpuPkg::clsJal: destination = cpuPkg::linkReg;
			default:        destination = '0;
		endcase
	end

	assign zeroExtend = (opClass == cpuPkg::clsOri);
	assign readyAtId  = (opClass == cpuPkg::clsLui) || (opClass == cpuPkg::clsJal);
	// Everything with a result except lw
	assign readyAtEx  = readyAtId || (opClass inside {cpuPkg::clsAddu, cpuPkg::clsSubu,
		cpuPkg::clsOri, cpuPkg::clsSll});

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::regAddr readAddr0,
	input  cpuPkg::regAddr readAddr1,
	input  logic           writeEnable,
	input  cpuPkg::regAddr writeAddr,
	input  cpuPkg::word    writeData,
	output cpuPkg::word    readData0,
	output cpuPkg::word    readData1
);
	cpuPkg::word regs [32];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeAddr != '0)
			regs[writeAddr] <= writeData; // $0 stays zero
	end

	// Write-before-read so WB and ID overlap in one cycle, never for $0
	assign readData0 = (writeEnable && writeAddr != '0 && writeAddr == readAddr0) ? writeData :
		regs[readAddr0];
	assign readData1 = (writeEnable && writeAddr != '0 && writeAddr == readAddr1) ? writeData :
		regs[readAddr1];

	// $0 reads zero on both ports
	zeroReg: assert property (@(posedge clk) disable iff (reset)
		(readAddr0 != '0 || readData0 == '0) && (readAddr1 != '0 || readData1 == '0));

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stall,
	input  cpuPkg::word          ifIdInstr,
	input  cpuPkg::word          ifIdPc,
	input  cpuPkg::operandSource sel0,
	input  cpuPkg::operandSource sel1,
	output cpuPkg::idExReg       idEx,
	input  cpuPkg::exMemReg      exMem,
	input  cpuPkg::memWbReg      memWb,
	output cpuPkg::regAddr       rs,
	output cpuPkg::regAddr       rt,
	output logic                 redirect,
	output cpuPkg::word          redirectPc
);
	cpuPkg::instrClass opClass;
	cpuPkg::regAddr    destination;
	logic              zeroExtend;
	logic              readyAtId;
	logic              readyAtEx;
	cpuPkg::word       readData0;
	cpuPkg::word       readData1;
	cpuPkg::word       rsValue;
	cpuPkg::word       rtValue;
	cpuPkg::word       imm;
	cpuPkg::word       pcPlus4;
	cpuPkg::word       earlyResult;
	logic              taken;

	// Forwarding mux, same for both operands
	function automatic cpuPkg::word pickOperand(
		input cpuPkg::operandSource sel,
		input cpuPkg::word          fileValue,
		input cpuPkg::word          early,
		input cpuPkg::word          alu,
		input cpuPkg::word          writeBack
	);
		case (sel)
			cpuPkg::fromDecodeEx: pickOperand = early;
			cpuPkg::fromExMem:    pickOperand = alu;
			cpuPkg::fromMemWb:    pickOperand = writeBack;
			default:              pickOperand = fileValue;
		endcase
	endfunction

	instrDecoder decoder (.instr(ifIdInstr), .opClass(opClass), .rs(rs), .rt(rt),
		.destination(destination), .zeroExtend(zeroExtend), .readyAtId(readyAtId),
		.readyAtEx(readyAtEx));

	regFile registers (.clk(clk), .reset(reset), .readAddr0(rs), .readAddr1(rt),
		.writeEnable(memWb.writeEnable), .writeAddr(memWb.destination),
		.writeData(memWb.data), .readData0(readData0), .readData1(readData1));

	////////////////////////////////////////////////////////////
	// Operands
	assign rsValue = (opClass == cpuPkg::clsSll) ? {27'd0, ifIdInstr[10:6]} :
		pickOperand(sel0, readData0, idEx.earlyResult, exMem.aluResult, memWb.data);
	assign rtValue = pickOperand(sel1, readData1, idEx.earlyResult, exMem.aluResult,
		memWb.data);
	assign imm     = zeroExtend ? {16'd0, ifIdInstr[15:0]} :
		{{16{ifIdInstr[15]}}, ifIdInstr[15:0]};
	assign pcPlus4 = ifIdPc + 32'd4;

	// lui and jal finish here
	assign earlyResult = (opClass == cpuPkg::clsLui) ? {ifIdInstr[15:0], 16'd0} :
		(opClass == cpuPkg::clsJal) ? ifIdPc + 32'd8 : '0;

	////////////////////////////////////////////////////////////
	// Branch and jump
	assign taken    = (opClass == cpuPkg::clsBeq) && (rsValue == rtValue);
	assign redirect = !stall && (taken || opClass inside {cpuPkg::clsJ, cpuPkg::clsJal,
		cpuPkg::clsJr}); // Operands are stale while stalled

	always_comb
	begin
		case (opClass)
			cpuPkg::clsBeq:             redirectPc = pcPlus4 + {imm[29:0], 2'b00};
			cpuPkg::clsJ, cpuPkg::clsJal: redirectPc = {pcPlus4[31:28], ifIdInstr[25:0], 2'b00};
			cpuPkg::clsJr:              redirectPc = rsValue;
			default:                    redirectPc = pcPlus4;
		endcase
	end

	////////////////////////////////////////////////////////////
	// ID/EX register
	always_ff @(posedge clk)
	begin
		if (reset || stall)
			idEx <= cpuPkg::idExNop; // Bubble into EX
		else
		begin
			idEx.opClass     <= opClass;
			idEx.destination <= destination;
			idEx.rsValue     <= rsValue;
			idEx.rtValue     <= rtValue;
			idEx.imm         <= imm;
			idEx.shamt       <= ifIdInstr[10:6];
			idEx.earlyResult <= earlyResult;
			idEx.resultReady <= readyAtId;
			idEx.pc          <= ifIdPc;
		end
	end

	// Producers the decoder calls late are still pending in EX/MEM two cycles on
	lateResult: assert property (@(posedge clk) disable iff (reset)
		(!stall && destination != '0 && !readyAtEx) |-> ##2 !exMem.resultReady);

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::idExReg  idEx,
	output cpuPkg::exMemReg exMem
);
	cpuPkg::word aluResult;

	// ALU
	always_comb
	begin
		case (idEx.opClass)
			cpuPkg::clsAddu: aluResult = idEx.rsValue + idEx.rtValue;
			cpuPkg::clsSubu: aluResult = idEx.rsValue - idEx.rtValue;
			cpuPkg::clsOri:  aluResult = idEx.rsValue | idEx.imm;  // imm zero-extended
			cpuPkg::clsSll:  aluResult = idEx.rtValue << idEx.shamt;
			cpuPkg::clsLw,
			cpuPkg::clsSw:   aluResult = idEx.rsValue + idEx.imm;  // Address
			cpuPkg::clsLui,
			cpuPkg::clsJal:  aluResult = idEx.earlyResult;
			default:         aluResult = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// EX/MEM register
	always_ff @(posedge clk)
	begin
		if (reset)
			exMem <= cpuPkg::exMemNop;
		else
		begin
			exMem.opClass     <= idEx.opClass;
			exMem.destination <= idEx.destination;
			exMem.aluResult   <= aluResult;
			exMem.storeData   <= idEx.rtValue;
			// Only a load still lacks its value here
			exMem.resultReady <= idEx.resultReady || (idEx.opClass != cpuPkg::clsLw);
			exMem.pc          <= idEx.pc;
		end
	end

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage (
	input  logic            clk,
	input  logic            reset,
	input  cpuPkg::exMemReg exMem,
	output cpuPkg::memWbReg memWb,
	output logic            traceValid,
	output cpuPkg::word     tracePc,
	output cpuPkg::regAddr  traceReg,
	output cpuPkg::word     traceData
);
	cpuPkg::word dataMem [cpuPkg::dataMemWords];
	logic [cpuPkg::dataMemIndexBits-1:0] memIndex;

	assign memIndex = exMem.aluResult[cpuPkg::dataMemIndexBits+1:2]; // Word address

	always_ff @(posedge clk)
	begin
		if (exMem.opClass == cpuPkg::clsSw)
			dataMem[memIndex] <= exMem.storeData;
	end

	////////////////////////////////////////////////////////////
	// MEM/WB register
	always_ff @(posedge clk)
	begin
		if (reset)
			memWb <= cpuPkg::memWbNop;
		else
		begin
			memWb.writeEnable <= (exMem.destination != '0); // $0 never written
			memWb.destination <= exMem.destination;
			memWb.data        <= (exMem.opClass == cpuPkg::clsLw) ? dataMem[memIndex] :
				exMem.aluResult;
			memWb.pc          <= exMem.pc;
		end
	end

	// Trace lags write-back by one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			traceValid <= 1'b0;
		else
			traceValid <= memWb.writeEnable;
	end

	always_ff @(posedge clk)
	begin
		tracePc   <= memWb.pc;
		traceReg  <= memWb.destination;
		traceData <= memWb.data;
	end

	// Address comes from the EX adder
	wordAligned: assert property (@(posedge clk) disable iff (reset)
		(exMem.opClass inside {cpuPkg::clsLw, cpuPkg::clsSw}) |-> exMem.aluResult[1:0] == 2'b00);

endmodule

// ==== source/hazardControl.sv ====
`timescale 1ns/1ps

module hazardControl (
	input  logic                 clk,
	input  logic                 reset,
	input  cpuPkg::regAddr       rs,
	input  cpuPkg::regAddr       rt,
	input  cpuPkg::idExReg       idEx,
	input  cpuPkg::exMemReg      exMem,
	input  cpuPkg::memWbReg      memWb,
	output logic                 stall,
	output cpuPkg::operandSource sel0,
	output cpuPkg::operandSource sel1
);
	logic rsPending;
	logic rtPending;

	// Youngest producer wins
	function automatic cpuPkg::operandSource findProducer(
		input  cpuPkg::regAddr  src,
		input  cpuPkg::idExReg  de,
		input  cpuPkg::exMemReg em,
		input  cpuPkg::memWbReg mw,
		output logic            notReady
	);
		findProducer = cpuPkg::fromRegFile;
		notReady     = 1'b0;
		if (src == '0)
			findProducer = cpuPkg::fromRegFile; // $0 needs nothing
		else if (de.destination == src)
		begin
			findProducer = cpuPkg::fromDecodeEx;
			notReady     = !de.resultReady;
		end
		else if (em.destination == src)
		begin
			findProducer = cpuPkg::fromExMem;
			notReady     = !em.resultReady;
		end
		else if (mw.writeEnable && mw.destination == src)
			findProducer = cpuPkg::fromMemWb;
	endfunction

	always_comb
	begin
		sel0  = findProducer(rs, idEx, exMem, memWb, rsPending);
		sel1  = findProducer(rt, idEx, exMem, memWb, rtPending);
		stall = rsPending || rtPending;
	end

	// Worst case is a load feeding the next instruction
	stallBound: assert property (@(posedge clk) disable iff (reset) not (stall [*3]));

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
	input  logic           clk,
	input  logic           reset,
	output cpuPkg::word    instrAddr,
	input  cpuPkg::word    instrData,
	output logic           traceValid,
	output cpuPkg::word    tracePc,
	output cpuPkg::regAddr traceReg,
	output cpuPkg::word    traceData
);
	cpuPkg::word          ifIdInstr;
	cpuPkg::word          ifIdPc;
	logic                 stall;
	logic                 redirect;
	cpuPkg::word          redirectPc;
	cpuPkg::operandSource sel0;
	cpuPkg::operandSource sel1;
	cpuPkg::regAddr       rs;
	cpuPkg::regAddr       rt;
	cpuPkg::idExReg       idEx;
	cpuPkg::exMemReg      exMem;
	cpuPkg::memWbReg      memWb;

	fetchStage fetch (.clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
		.redirectPc(redirectPc), .instrData(instrData), .instrAddr(instrAddr),
		.ifIdInstr(ifIdInstr), .ifIdPc(ifIdPc));

	// Also holds the register file, written from MEM/WB
	decodeStage decode (.clk(clk), .reset(reset), .stall(stall), .ifIdInstr(ifIdInstr),
		.ifIdPc(ifIdPc), .sel0(sel0), .sel1(sel1), .idEx(idEx), .exMem(exMem),
		.memWb(memWb), .rs(rs), .rt(rt), .redirect(redirect), .redirectPc(redirectPc));

	executeStage execute (.clk(clk), .reset(reset), .idEx(idEx), .exMem(exMem));

	memoryStage memory (.clk(clk), .reset(reset), .exMem(exMem), .memWb(memWb),
		.traceValid(traceValid), .tracePc(tracePc), .traceReg(traceReg),
		.traceData(traceData));

	////////////////////////////////////////////////////////////
	// Stall and forwarding control
	hazardControl hazard (.clk(clk), .reset(reset), .rs(rs), .rt(rt), .idEx(idEx),
		.exMem(exMem), .memWb(memWb), .stall(stall), .sel0(sel0), .sel1(sel1));

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk; // 100 ns period
	end

endmodule

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

	localparam int patternDepth = 128;       // Words in the pattern image
	localparam int traceTimeout = 200;       // Cycles allowed per write-back

	logic           clk;
	logic           reset;
	cpuPkg::word    instrAddr;
	cpuPkg::word    instrData;
	logic           traceValid;
	cpuPkg::word    tracePc;
	cpuPkg::regAddr traceReg;
	cpuPkg::word    traceData;

	logic [31:0] patterns [patternDepth];    // Length, program, count, triples
	logic [31:0] progLength;
	logic [31:0] traceCount;

	clockGen clockSource (.clk(clk));

	cpuTop UUT (.clk(clk), .reset(reset), .instrAddr(instrAddr), .instrData(instrData),
		.traceValid(traceValid), .tracePc(tracePc), .traceReg(traceReg),
		.traceData(traceData));

	////////////////////////////////////////////////////////////
	// Failure reporting

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			abortRun($sformatf("MISMATCH %s: expected %h, actual %h", testName, expected,
				actual));
	endtask

	////////////////////////////////////////////////////////////
	// Instruction memory

	// Words outside the program read as nop
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - cpuPkg::resetPc;
		if (offset[1:0] == 2'b00 && (offset >> 2) < progLength)
			fetchWord = patterns[1 + (offset >> 2)];
		else
			fetchWord = 32'h0;
	endfunction

	// Answer the fetch half a cycle after the PC moves
	always @(negedge clk)
		instrData = fetchWord(instrAddr);

	////////////////////////////////////////////////////////////
	// Trace handling

	// Next cycle with a write-back, sampled where outputs are stable
	task automatic waitForTrace(input int entry);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (traceValid !== 1'b1)
		begin
			cycles++;
			if (cycles >= traceTimeout)
				abortRun($sformatf("Timeout: no write-back arrived for trace entry %0d in %0d cycles",
					entry, traceTimeout));
			else
				@(negedge clk);
		end
	endtask

	initial
	begin
		int entry;
		int base;
		reset     = 1'b1;
		instrData = 32'h0;

		$readmemh("dv/cpuPatterns.hex", patterns);
		progLength = patterns[0];
		if ($isunknown(progLength) || progLength == 0 || progLength > patternDepth - 2)
			abortRun("Pattern file is missing or has a bad program length");
		traceCount = patterns[progLength + 1];
		base       = progLength + 2;                 // First triple
		if ($isunknown(traceCount) || traceCount == 0 ||
			base + 3 * traceCount > patternDepth)
			abortRun("Pattern file has a bad trace count");

		repeat (2) @(posedge clk);                   // Two reset cycles
		@(negedge clk);
		reset = 1'b0;

		// Entries come in program order, delay slots included
		for (entry = 0; entry < traceCount; entry++)
		begin
			waitForTrace(entry);
			checkValue($sformatf("trace %0d pc", entry), patterns[base], tracePc);
			checkValue($sformatf("trace %0d reg", entry), patterns[base + 1],
				{27'd0, traceReg});
			checkValue($sformatf("trace %0d data", entry), patterns[base + 2], traceData);
			base = base + 3;
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== dv/cpuPatterns.hex ====
// Program length, then one instruction word per line from 0x3000
// Trace count, then one write-back per line as pc, register, data
00000018
34011234 // ori  $1, $0, 0x1234
3C02ABCD // lui  $2, 0xabcd
00221821 // addu $3, $1, $2
00612023 // subu $4, $3, $1
00042900 // sll  $5, $4, 4
AC050008 // sw   $5, 8($0)
8C060008 // lw   $6, 8($0)
00C13821 // addu $7, $6, $1
00E70021 // addu $0, $7, $7
10010002 // beq  $0, $1 not taken
34080005 // ori  $8, $0, 5 delay slot
11080002 // beq  $8, $8 taken to 0x3038
34090009 // ori  $9, $0, 9 delay slot
340ADEAD // ori  $10 skipped
0C000C12 // jal  0x3048
340B0011 // ori  $11 delay slot
08000C16 // j    0x3058
340C0012 // ori  $12 delay slot
03E06821 // addu $13, $31, $0
03E00008 // jr   $31
340E0014 // ori  $14 delay slot
340ABEEF // ori  $10 skipped
3C0F0001 // lui  $15, 1
01ED8021 // addu $16, $15, $13
00000010
00003000 00000001 00001234
00003004 00000002 ABCD0000
00003008 00000003 ABCD1234
0000300C 00000004 ABCD0000
00003010 00000005 BCD00000
00003018 00000006 BCD00000
0000301C 00000007 BCD01234
00003028 00000008 00000005
00003030 00000009 00000009
00003038 0000001F 00003040
0000303C 0000000B 00000011
00003048 0000000D 00003040
00003050 0000000E 00000014
00003044 0000000C 00000012
00003058 0000000F 00010000
0000305C 00000010 00013040

// ==== verilog.f ====
source/cpuPkg.sv
source/fetchStage.sv
source/instrDecoder.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardControl.sv
source/cpuTop.sv
dv/clockGen.sv
dv/cpuTb.sv

// ==== Bender.yml ====
package:
  name: pipelined_cpu

sources:
  - source/cpuPkg.sv
  - source/fetchStage.sv
  - source/instrDecoder.sv
  - source/regFile.sv
  - source/decodeStage.sv
  - source/executeStage.sv
  - source/memoryStage.sv
  - source/hazardControl.sv
  - source/cpuTop.sv
  - target: test
    files:
      - dv/clockGen.sv
      - dv/cpuTb.sv
